// ==== rtl/sysinfo_cfg_pkg.sv ====
//##########################################################################
// status readout configuration constants
// bus widths, BCD digit counts, bank statistics and the rate window
//##########################################################################

package sysinfo_cfg_pkg;

    // host status bus
    localparam int ST_ADDR_W = 8;
    localparam int ST_DATA_W = 8;

    // frame counter, five BCD digits
    localparam int FRAME_DIGITS = 5;
    localparam int FRAME_W = FRAME_DIGITS * 4;   // 20 bits

    // sample rate readout, saturates at 99
    localparam int RATE_DIGITS = 2;
    localparam int RATE_W = RATE_DIGITS * 4;

    // memory ready strobes, one counter per bank
    localparam int NUM_BANKS = 4;
    localparam int STAT_W = 8;                   // saturating at 255

    // measurement window in clk cycles
    // kept short so a simulation sees many windows
    localparam int RATE_WINDOW = 1000;
    localparam int WIN_W = $clog2(RATE_WINDOW);

    // board switches
    localparam int DIP_W = 24;

endpackage

// ==== rtl/sysinfo_types_pkg.sv ====
//##########################################################################
// status readout types
// host request/response structs, board inputs, bank counts
// read FSM states and status address groups
//##########################################################################

package sysinfo_types_pkg;
    import sysinfo_cfg_pkg::*;

    // host to block
    typedef struct packed {
        logic [ST_ADDR_W-1:0] addr;
        logic                 req;    // four-phase request
    } st_req_t;

    // block to host
    typedef struct packed {
        logic [ST_DATA_W-1:0] data;
        logic                 ack;
    } st_rsp_t;

    // slow board inputs, all sampled as-is
    typedef struct packed {
        logic [DIP_W-1:0] dipsw;
        logic [6:0]       core_mod;
        logic [1:0]       dial_x;
        logic             game_led;
        logic             dip_flip;
        logic             dip_pause;    // high lets the game run
        logic             ioctl_ram;    // loader flags
        logic             ioctl_rom;
        logic             ioctl_cart;
        logic [8:0]       mouse_dx;
        logic [8:0]       mouse_dy;
        logic [7:0]       mouse_f;      // buttons
    } board_in_t;

    // one count per bank, index 0 is bank 0
    typedef struct packed {
        logic [NUM_BANKS-1:0][STAT_W-1:0] cnt;
    } bank_counts_t;

    typedef enum logic [1:0] {
        IDLE,
        SELECT,   // address captured, mux registering
        ACK
    } read_state_e;

    // top two status address bits
    typedef enum logic [1:0] {
        FRAME_GRP    = 2'd0,
        MEM_GRP      = 2'd1,
        RATE_DIP_GRP = 2'd2,
        INPUT_GRP    = 2'd3
    } st_group_e;

endpackage

// ==== rtl/bcd_counter.sv ====
//##########################################################################
// multi-digit BCD up-counter
// ripple carry over the digits, synchronous clear
// wraps to zero or holds at all nines
//##########################################################################

module bcd_counter #(
    parameter int DIGITS = 5,
    parameter bit WRAP   = 1'b1      // 0 saturates at 9..9
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    input  logic                  up,
    output logic [DIGITS*4-1:0]   cnt
);

    logic [DIGITS:0]     carry;     // carry into each digit
    logic [DIGITS*4-1:0] nxt;
    logic                hold;

    assign carry[0] = 1'b1;         // +1 enters at the lowest digit

    for (genvar g = 0; g < DIGITS; g++) begin : g_digit
        logic [3:0] d;
        assign d = cnt[g*4 +: 4];
        assign carry[g+1] = carry[g] & (d == 4'd9);
        assign nxt[g*4 +: 4] = !carry[g] ? d : (d == 4'd9 ? 4'd0 : d + 4'd1);

        // digit never leaves 0..9, whatever mix of clr and up
        a_digit_range: assert property (@(posedge clk) disable iff (rst) d <= 4'd9)
            else $error("bcd digit %0d holds %h", g, d);
    end

    // carry out of the top digit means all nines
    assign hold = !WRAP && carry[DIGITS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            // an event in the clear cycle opens the new count
            cnt <= {{(DIGITS*4-1){1'b0}}, up};
        end else if (up && !hold) begin
            cnt <= nxt;
        end
    end

endmodule

// ==== rtl/sample_rate_meter.sv ====
//##########################################################################
// audio sample rate meter
// counts sample rising edges per window into a saturating BCD count
// and latches the result at the window end
//##########################################################################

module sample_rate_meter (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               sample,
    output logic [sysinfo_cfg_pkg::RATE_W-1:0] srate
);
    import sysinfo_cfg_pkg::*;

    logic [WIN_W-1:0]  win_cnt;     // position in the window
    logic              win_end;
    logic              sample_l;    // last sample level
    logic              sample_up;
    logic [RATE_W-1:0] scnt;        // running BCD edge count

    assign win_end   = win_cnt == WIN_W'(RATE_WINDOW - 1);
    assign sample_up = sample & ~sample_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_cnt  <= '0;
            sample_l <= 1'b0;
            srate    <= '0;
        end else begin
            sample_l <= sample;
            if (win_end) begin
                win_cnt <= '0;
                srate   <= scnt;     // edges of the window just closed
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    // cleared on win_end, so each window starts fresh
    bcd_counter #(
        .DIGITS ( RATE_DIGITS ),
        .WRAP   ( 1'b0        )      // stick at 99
    ) u_rate_cnt (
        .clk    ( clk       ),
        .rst    ( rst       ),
        .clr    ( win_end   ),
        .up     ( sample_up ),
        .cnt    ( scnt      )
    );

endmodule

// ==== rtl/bank_stats.sv ====
//##########################################################################
// memory bank statistics
// per-bank saturating counts of ready strobes, latched per frame
//##########################################################################

module bank_stats (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [sysinfo_cfg_pkg::NUM_BANKS-1:0] ba_rdy,
    input  logic                                  frame_up,
    output sysinfo_types_pkg::bank_counts_t       counts
);
    import sysinfo_cfg_pkg::*;
    import sysinfo_types_pkg::*;

    logic [NUM_BANKS-1:0][STAT_W-1:0] run;   // counts of the frame in progress

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run    <= '0;
            counts <= '0;
        end else begin
            if (frame_up) begin
                counts.cnt <= run;   // snapshot of the closed frame
            end
            for (int i = 0; i < NUM_BANKS; i++) begin
                if (frame_up) begin
                    // restart, a strobe right now belongs to the new frame
                    run[i] <= STAT_W'(ba_rdy[i]);
                end else if (ba_rdy[i] && run[i] != '1) begin
                    run[i] <= run[i] + 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_chk
        // only a frame boundary brings a running count down
        a_run_mono: assert property (@(posedge clk) disable iff (rst)
            !frame_up |=> run[g] >= $past(run[g]))
            else $error("bank %0d count went down", g);
    end

endmodule

// ==== rtl/status_mux.sv ====
//##########################################################################
// status byte selection
// registered decode of the status address into one byte
// groups: frame count, memory/loader, rate/DIP, inputs
//##########################################################################

module status_mux (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [sysinfo_cfg_pkg::ST_ADDR_W-1:0] addr,
    input  logic [sysinfo_cfg_pkg::FRAME_W-1:0]   frame_bcd,
    input  logic [sysinfo_cfg_pkg::RATE_W-1:0]    srate,
    input  sysinfo_types_pkg::bank_counts_t       counts,
    input  sysinfo_types_pkg::board_in_t          board,
    output logic [sysinfo_cfg_pkg::ST_DATA_W-1:0] dout
);
    import sysinfo_cfg_pkg::*;
    import sysinfo_types_pkg::*;

    st_group_e  grp;
    logic [1:0] sel;    // sub-block within a group
    logic [1:0] idx;    // low bits, frame byte or bank

    assign grp = st_group_e'(addr[ST_ADDR_W-1 -: 2]);
    assign sel = addr[5:4];
    assign idx = addr[1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else begin
            unique case (grp)
                FRAME_GRP: begin
                    case (idx)
                        2'd0:    dout <= frame_bcd[15:8];
                        2'd1:    dout <= frame_bcd[7:0];
                        2'd2:    dout <= {4'd0, frame_bcd[19:16]};  // top digit
                        default: dout <= '0;
                    endcase
                end
                MEM_GRP: begin
                    case (sel)
                        2'd0: dout <= counts.cnt[idx];   // last full frame
                        2'd1: begin
                            // loader flags
                            dout <= {3'd0, board.ioctl_ram, 2'd0,
                                     board.ioctl_cart, board.ioctl_rom};
                        end
                        default: dout <= '0;
                    endcase
                end
                RATE_DIP_GRP: begin
                    case (sel)
                        2'd0: dout <= srate;
                        2'd1: dout <= board.dipsw[0 +: ST_DATA_W];
                        2'd2: dout <= board.dipsw[8 +: ST_DATA_W];
                        2'd3: dout <= board.dipsw[16 +: ST_DATA_W];
                    endcase
                end
                INPUT_GRP: begin
                    case (sel)
                        2'd0: begin
                            dout <= {board.core_mod[3:0], board.dial_x,
                                     board.game_led, board.dip_flip};
                        end
                        2'd1: dout <= board.mouse_dx[8:1];   // drop the LSB
                        2'd2: dout <= board.mouse_dy[8:1];
                        2'd3: dout <= board.mouse_f;
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== rtl/status_read_ctrl.sv ====
//##########################################################################
// four-phase req/ack read controller
// captures the status address, waits for the registered mux
// then presents the byte with ack until req drops
//##########################################################################

module status_read_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    input  sysinfo_types_pkg::st_req_t            req,
    output sysinfo_types_pkg::st_rsp_t            rsp,
    output logic [sysinfo_cfg_pkg::ST_ADDR_W-1:0] addr,
    input  logic [sysinfo_cfg_pkg::ST_DATA_W-1:0] dout
);
    import sysinfo_types_pkg::*;

    read_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            addr  <= '0;
            rsp   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req.req) begin
                        addr  <= req.addr;   // host keeps it stable anyway
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    state <= ACK;            // mux registers on this edge
                end
                ACK: begin
                    if (!rsp.ack) begin
                        // first cycle here, mux output now valid
                        rsp.data <= dout;
                        rsp.ack  <= 1'b1;
                    end else if (!req.req) begin
                        rsp.ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // no ack outside a transfer
    a_idle_no_ack: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !rsp.ack)
        else $error("ack high in IDLE");

    // data frozen for as long as the host sees ack
    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        rsp.ack |=> !rsp.ack || $stable(rsp.data))
        else $error("rsp.data changed under ack");

    // ack comes two cycles after a request is taken
    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        state == IDLE && req.req |=> !rsp.ack ##1 !rsp.ack ##1 rsp.ack)
        else $error("ack latency off");

endmodule

// ==== rtl/sys_info_top.sv ====
//##########################################################################
// status and debug readout top level
// LVBL edge detect for the frame count, rate meter, bank stats,
// status byte mux and the req/ack read controller
//##########################################################################

module sys_info_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  sysinfo_types_pkg::st_req_t            req,
    output sysinfo_types_pkg::st_rsp_t            rsp,
    input  sysinfo_types_pkg::board_in_t          board,
    input  logic                                  lvbl,
    input  logic                                  sample,
    input  logic [sysinfo_cfg_pkg::NUM_BANKS-1:0] ba_rdy
);
    import sysinfo_cfg_pkg::*;
    import sysinfo_types_pkg::*;

    logic                 lvbl_l;      // LVBL one cycle late
    logic                 frame_up;    // registered, one pulse per running frame
    logic [FRAME_W-1:0]   frame_bcd;
    logic [RATE_W-1:0]    srate;
    bank_counts_t         counts;
    logic [ST_ADDR_W-1:0] st_addr;     // captured by the controller
    logic [ST_DATA_W-1:0] st_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b0;
            frame_up <= 1'b0;
        end else begin
            lvbl_l   <= lvbl;
            frame_up <= lvbl & ~lvbl_l & board.dip_pause;   // paused frames skipped
        end
    end

    bcd_counter #(.DIGITS(FRAME_DIGITS), .WRAP(1'b1)) u_frame_cnt (
        .clk ( clk ), .rst ( rst ), .clr ( 1'b0 ), .up ( frame_up ), .cnt ( frame_bcd )
    );

    sample_rate_meter u_rate (
        .clk ( clk ), .rst ( rst ), .sample ( sample ), .srate ( srate )
    );

    bank_stats u_stats (
        .clk ( clk ), .rst ( rst ), .ba_rdy ( ba_rdy ), .frame_up ( frame_up ),
        .counts ( counts )
    );

    status_mux u_mux (
        .clk ( clk ), .rst ( rst ), .addr ( st_addr ), .frame_bcd ( frame_bcd ),
        .srate ( srate ), .counts ( counts ), .board ( board ), .dout ( st_dout )
    );

    status_read_ctrl u_ctrl (
        .clk ( clk ), .rst ( rst ), .req ( req ), .rsp ( rsp ),
        .addr ( st_addr ), .dout ( st_dout )
    );

endmodule

// ==== testbench/tb_sys_info.sv ====
//##########################################################################
// testbench for the status readout top level
// clock, reset, xorshift stimulus, four-phase reads, reference byte model,
// checker process and per-test report
//##########################################################################

module tb_sys_info;
    import sysinfo_cfg_pkg::*;
    import sysinfo_types_pkg::*;

    logic         clk = 1'b0;
    logic         rst;
    st_req_t      req;
    st_rsp_t      rsp;
    board_in_t    board;
    logic         lvbl;
    logic         sample;
    logic [3:0]   ba_rdy;

    logic [31:0]  rng = 32'd59257;   // xorshift state
    int           sample_period;     // 0 stops the sample pulses
    int           frame_cnt;         // frames the DUT should have counted
    int           exp_rate;          // sample edges per window, saturated
    int           exp_bank [4];      // latched bank counts
    int           cycles;
    int           checks;
    int           errors;
    int           test_err0;         // errors when the current test began
    string        test_name;
    logic [7:0]   rd_addr;
    logic [7:0]   rd_data;
    event         rd_done;

    always #4 clk = ~clk;            // period 8

    sys_info_top sys_info_top_i (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .req    ( req    ),
        .rsp    ( rsp    ),
        .board  ( board  ),
        .lvbl   ( lvbl   ),
        .sample ( sample ),
        .ba_rdy ( ba_rdy )
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // binary to packed BCD, lowest digit in the low nibble
    function automatic logic [FRAME_W-1:0] to_bcd(input int v);
        logic [FRAME_W-1:0] b;
        int n;
        b = '0;
        n = v;
        for (int i = 0; i < FRAME_DIGITS; i++) begin
            b[i*4 +: 4] = 4'(n % 10);
            n = n / 10;
        end
        return b;
    endfunction

    // status map, byte by byte
    function automatic logic [7:0] expected_byte(input logic [7:0] a);
        logic [FRAME_W-1:0] f;
        logic [FRAME_W-1:0] rb;
        logic [7:0] r;
        f  = to_bcd(frame_cnt);
        rb = to_bcd(exp_rate);
        r  = 8'h00;                  // unused slots read zero
        case (a[7:6])
            2'd0: begin
                if (a[1:0] == 2'd0) r = f[15:8];
                else if (a[1:0] == 2'd1) r = f[7:0];
                else if (a[1:0] == 2'd2) r = {4'h0, f[19:16]};
            end
            2'd1: begin
                if (a[5:4] == 2'd0) begin
                    r = 8'(exp_bank[a[1:0]]);
                end else if (a[5:4] == 2'd1) begin
                    r = {3'b000, board.ioctl_ram, 2'b00, board.ioctl_cart, board.ioctl_rom};
                end
            end
            2'd2: begin
                if (a[5:4] == 2'd0) r = rb[7:0];
                else r = board.dipsw[(int'(a[5:4]) - 1) * 8 +: 8];   // DIP byte 0..2
            end
            default: begin
                case (a[5:4])
                    2'd0: r = {board.core_mod[3:0], board.dial_x, board.game_led,
                               board.dip_flip};
                    2'd1: r = board.mouse_dx[8:1];
                    2'd2: r = board.mouse_dy[8:1];
                    default: r = board.mouse_f;
                endcase
            end
        endcase
        return r;
    endfunction

    // compares every completed read against the model
    always @(rd_done) begin
        logic [7:0] exp_d;
        exp_d = expected_byte(rd_addr);
        checks++;
        if (rd_data !== exp_d) begin
            $display("FAILED rsp.data at addr %h: got %h, expected %h", rd_addr, rd_data, exp_d);
            errors++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 6 * RATE_WINDOW + 4000) begin
            $display("timeout: the run did not finish within %0d cycles", cycles - 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    // one sample pulse every sample_period cycles
    initial begin
        int ph;
        sample = 1'b0;
        ph = 0;
        forever begin
            @(posedge clk);
            #1;
            if (sample_period == 0) begin
                sample = 1'b0;
                ph = 0;
            end else begin
                sample = (ph == 0);
                ph = (ph + 1) % sample_period;
            end
        end
    end

    // full four-phase read, entered 1 unit after a rising edge
    task automatic read_byte(input logic [7:0] a, input int hold, output logic [7:0] d);
        int n;
        req.addr = a;
        req.req  = 1'b1;
        n = 0;
        while (!rsp.ack && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        if (!rsp.ack) begin
            $display("read at addr %h got no ack within %0d cycles", a, n);
            errors++;
        end else if (n != 3) begin
            $display("FAILED ack latency at addr %h: got %h, expected %h", a, n, 3);
            errors++;
        end
        d = rsp.data;
        repeat (hold) begin          // host stalls, ack and data must hold
            @(posedge clk);
            #1;
            checks++;
            if (!rsp.ack || rsp.data !== d) begin
                $display("FAILED rsp under stall at addr %h: ack %h data %h, expected 1 %h",
                         a, rsp.ack, rsp.data, d);
                errors++;
            end
        end
        rd_addr = a;
        rd_data = d;
        -> rd_done;
        req.req = 1'b0;
        @(posedge clk);
        #1;
        checks++;
        if (rsp.ack) begin
            $display("FAILED rsp.ack after req drop: got %h, expected %h", rsp.ack, 1'b0);
            errors++;
        end
    endtask

    task automatic pulse_lvbl();
        lvbl = 1'b1;
        repeat (2) @(posedge clk);
        #1 lvbl = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic report_test();
        $display("test %s: %0d errors", test_name, errors - test_err0);
    endtask

    initial begin
        logic [7:0]  d;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [7:0]  addrs [8];
        rst = 1'b1;
        req = '0;
        board = '0;
        board.dipsw = 24'h5a3c96;
        board.dip_pause = 1'b1;
        lvbl = 1'b0;
        ba_rdy = '0;
        sample_period = 0;
        frame_cnt = 0;
        exp_rate = 0;
        foreach (exp_bank[i]) exp_bank[i] = 0;
        cycles = 0;
        checks = 0;
        errors = 0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        begin_test("handshake");
        repeat (5) begin             // idle bus, no ack
            @(posedge clk);
            #1;
            checks++;
            if (rsp.ack) begin
                $display("FAILED rsp.ack with req low: got %h, expected %h", rsp.ack, 1'b0);
                errors++;
            end
        end
        read_byte(8'h90, 6, d);      // DIP byte 0, held 6 cycles
        report_test();

        begin_test("frame counter");
        for (int i = 0; i < 28; i++) begin
            board.dip_pause = !(i >= 10 && i < 15);   // 5 paused frames
            if (board.dip_pause) frame_cnt++;
            pulse_lvbl();
        end
        board.dip_pause = 1'b1;
        read_byte(8'h00, 0, d);
        read_byte(8'h01, 0, d);
        read_byte(8'h02, 0, d);
        read_byte(8'h03, 0, d);
        read_byte(8'h20, 0, d);
        report_test();

        begin_test("sample rate");
        sample_period = 20;          // 50 edges per window
        repeat (2 * RATE_WINDOW + 8) @(posedge clk);
        #1;
        exp_rate = RATE_WINDOW / 20;
        read_byte(8'h80, 0, d);
        sample_period = 8;           // 125 edges, over the top
        repeat (2 * RATE_WINDOW + 8) @(posedge clk);
        #1;
        exp_rate = (RATE_WINDOW / 8 > 99) ? 99 : RATE_WINDOW / 8;
        read_byte(8'h80, 0, d);
        sample_period = 0;
        report_test();

        begin_test("bank statistics");
        foreach (exp_bank[i]) exp_bank[i] = 0;
        lvbl = 1'b1;                 // opening frame edge
        @(posedge clk);
        #1;
        for (int i = 0; i < 400; i++) begin
            r1 = next_rand();
            ba_rdy = {r1[3], r1[2], r1[1], r1[0] | r1[4] | r1[8]};   // bank 0 saturates
            for (int b = 0; b < 4; b++) begin
                if (ba_rdy[b] && exp_bank[b] < 255) exp_bank[b]++;
            end
            if (i == 4) lvbl = 1'b0;
            if (i == 399) lvbl = 1'b1;   // closing frame edge
            @(posedge clk);
            #1;
        end
        ba_rdy = '0;
        frame_cnt += 2;
        @(posedge clk);              // closing frame_up latches the counts
        #1 lvbl = 1'b0;
        for (int b = 0; b < 4; b++) read_byte(8'h40 + 8'(b), 0, d);
        report_test();

        begin_test("static inputs");
        r1 = next_rand();
        r2 = next_rand();
        r3 = next_rand();
        board = board_in_t'({r3[0], r2, r1});   // 65 random bits
        addrs = '{8'h50, 8'h90, 8'ha0, 8'hb0, 8'hc0, 8'hd0, 8'he0, 8'hf0};
        foreach (addrs[i]) read_byte(addrs[i], 0, d);
        report_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/sysinfo_cfg_pkg.sv
rtl/sysinfo_types_pkg.sv
rtl/bcd_counter.sv
rtl/sample_rate_meter.sv
rtl/bank_stats.sv
rtl/status_mux.sv
rtl/status_read_ctrl.sv
rtl/sys_info_top.sv
testbench/tb_sys_info.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the status readout testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sys_info -f sources.f

# the simulation may stop early on an assertion, the output decides
out=$(./obj_dir/Vtb_sys_info) || true
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
